// File: logic/mempool_lite_pkg.sv
package mempool_lite_pkg;

  localparam int unsigned DataWidth       = 32;
  localparam int unsigned AddrWidth       = 32;
  localparam int unsigned StrbWidth       = DataWidth / 8;
  localparam int unsigned L2AddrWidth     = 10;
  localparam int unsigned L2NumWords      = 2 ** L2AddrWidth;
  localparam int unsigned L2ByteOffset    = 2;
  localparam int unsigned CtrlOffsetWidth = 16;

  typedef logic [AddrWidth-1:0]       addr_t;
  typedef logic [DataWidth-1:0]       data_t;
  typedef logic [StrbWidth-1:0]       strb_t;
  typedef logic [CtrlOffsetWidth-1:0] reg_offset_t;

  // Address map
  localparam addr_t CtrlBaseAddr = 32'h4000_0000;
  localparam addr_t CtrlEndAddr  = 32'h4000_FFFF;
  localparam addr_t L2BaseAddr   = 32'h8000_0000;
  localparam addr_t L2EndAddr    = 32'hBFFF_FFFF;

  localparam reg_offset_t WakeUpOffset    = 16'h0000;
  localparam reg_offset_t NumWordsOffset  = 16'h0004;
  localparam reg_offset_t SrcOffsetOffset = 16'h0008;
  localparam reg_offset_t EocOffset       = 16'h000C;

  typedef enum logic [1:0] {
    CtrlRegisters,
    L2Memory,
    External
  } target_e;

  typedef enum logic [1:0] {
    Idle,
    Fetch,
    Wait,
    WriteEoc
  } run_state_e;

  // Byte lane merge for partial writes
  function automatic data_t apply_be(data_t old_word, data_t new_word, strb_t be);
    data_t merged;
    merged = old_word;
    for (int b = 0; b < StrbWidth; b++) begin
      if (be[b]) merged[8*b +: 8] = new_word[8*b +: 8];
    end
    return merged;
  endfunction

endpackage : mempool_lite_pkg

// File: logic/mem_bus_if.sv
`timescale 1ns/10ps

interface mem_bus_if;

  // Master side
  logic                    req;
  logic                    we;
  mempool_lite_pkg::addr_t addr;
  mempool_lite_pkg::data_t wdata;
  mempool_lite_pkg::strb_t be;

  // Slave side
  logic                    gnt;
  logic                    rvalid;  // One cycle after a granted read
  mempool_lite_pkg::data_t rdata;

  modport mst (
    output req, we, addr, wdata, be,
    input  gnt, rvalid, rdata
  );

  modport slv (
    input  req, we, addr, wdata, be,
    output gnt, rvalid, rdata
  );

endinterface : mem_bus_if

// File: logic/bus_xbar.sv
`timescale 1ns/10ps

module bus_xbar (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  mem_bus_if.slv                  host_bus,
  mem_bus_if.slv                  engine_bus,
  mem_bus_if.mst                  ctrl_bus,
  mem_bus_if.mst                  l2_bus,
  output logic                    ext_req_o,
  output logic                    ext_we_o,
  output mempool_lite_pkg::addr_t ext_addr_o,
  output mempool_lite_pkg::data_t ext_wdata_o,
  output mempool_lite_pkg::strb_t ext_be_o,
  input  mempool_lite_pkg::data_t ext_rdata_i
);

  mempool_lite_pkg::target_e host_tgt, eng_tgt;
  mempool_lite_pkg::target_e host_src_q, eng_src_q;
  logic eng_win;
  logic host_on_ctrl, host_on_l2, host_on_ext;
  logic host_rd_q, eng_rd_q;

  function automatic mempool_lite_pkg::target_e decode(mempool_lite_pkg::addr_t addr);
    if (addr >= mempool_lite_pkg::CtrlBaseAddr && addr <= mempool_lite_pkg::CtrlEndAddr)
      return mempool_lite_pkg::CtrlRegisters;
    if (addr >= mempool_lite_pkg::L2BaseAddr && addr <= mempool_lite_pkg::L2EndAddr)
      return mempool_lite_pkg::L2Memory;
    return mempool_lite_pkg::External;  // Everything else goes off-chip
  endfunction

  function automatic logic tgt_ready(mempool_lite_pkg::target_e t, logic ctrl_g, logic l2_g);
    unique case (t)
      mempool_lite_pkg::CtrlRegisters: return ctrl_g;
      mempool_lite_pkg::L2Memory:      return l2_g;
      default:                         return 1'b1;
    endcase
  endfunction

  function automatic logic ret_valid(mempool_lite_pkg::target_e src, logic ctrl_v, logic l2_v);
    unique case (src)
      mempool_lite_pkg::CtrlRegisters: return ctrl_v;
      mempool_lite_pkg::L2Memory:      return l2_v;
      default:                         return 1'b1;
    endcase
  endfunction

  function automatic mempool_lite_pkg::data_t ret_data(mempool_lite_pkg::target_e src,
      mempool_lite_pkg::data_t ctrl_d, mempool_lite_pkg::data_t l2_d,
      mempool_lite_pkg::data_t ext_d);
    unique case (src)
      mempool_lite_pkg::CtrlRegisters: return ctrl_d;
      mempool_lite_pkg::L2Memory:      return l2_d;
      default:                         return ext_d;
    endcase
  endfunction

  assign host_tgt = decode(host_bus.addr);
  assign eng_tgt  = decode(engine_bus.addr);

  // Engine backs off when the host wants the same target
  assign eng_win = engine_bus.req && !(host_bus.req && host_tgt == eng_tgt);

  assign host_on_ctrl = host_bus.req && host_tgt == mempool_lite_pkg::CtrlRegisters;
  assign host_on_l2   = host_bus.req && host_tgt == mempool_lite_pkg::L2Memory;
  assign host_on_ext  = host_bus.req && host_tgt == mempool_lite_pkg::External;

  assign ctrl_bus.req   = host_on_ctrl || (eng_win && eng_tgt == mempool_lite_pkg::CtrlRegisters);
  assign ctrl_bus.we    = host_on_ctrl ? host_bus.we    : engine_bus.we;
  assign ctrl_bus.addr  = host_on_ctrl ? host_bus.addr  : engine_bus.addr;
  assign ctrl_bus.wdata = host_on_ctrl ? host_bus.wdata : engine_bus.wdata;
  assign ctrl_bus.be    = host_on_ctrl ? host_bus.be    : engine_bus.be;

  assign l2_bus.req   = host_on_l2 || (eng_win && eng_tgt == mempool_lite_pkg::L2Memory);
  assign l2_bus.we    = host_on_l2 ? host_bus.we    : engine_bus.we;
  assign l2_bus.addr  = host_on_l2 ? host_bus.addr  : engine_bus.addr;
  assign l2_bus.wdata = host_on_l2 ? host_bus.wdata : engine_bus.wdata;
  assign l2_bus.be    = host_on_l2 ? host_bus.be    : engine_bus.be;

  assign ext_req_o   = host_on_ext || (eng_win && eng_tgt == mempool_lite_pkg::External);
  assign ext_we_o    = host_on_ext ? host_bus.we    : engine_bus.we;
  assign ext_addr_o  = host_on_ext ? host_bus.addr  : engine_bus.addr;
  assign ext_wdata_o = host_on_ext ? host_bus.wdata : engine_bus.wdata;
  assign ext_be_o    = host_on_ext ? host_bus.be    : engine_bus.be;

  assign host_bus.gnt   = host_bus.req && tgt_ready(host_tgt, ctrl_bus.gnt, l2_bus.gnt);
  assign engine_bus.gnt = eng_win && tgt_ready(eng_tgt, ctrl_bus.gnt, l2_bus.gnt);

  // Remember who read from where, for the return cycle
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      host_rd_q  <= 1'b0;
      eng_rd_q   <= 1'b0;
      host_src_q <= mempool_lite_pkg::External;
      eng_src_q  <= mempool_lite_pkg::External;
    end else begin
      host_rd_q  <= host_bus.gnt && !host_bus.we;
      eng_rd_q   <= engine_bus.gnt && !engine_bus.we;
      host_src_q <= host_tgt;
      eng_src_q  <= eng_tgt;
    end
  end

  assign host_bus.rvalid = host_rd_q && ret_valid(host_src_q, ctrl_bus.rvalid, l2_bus.rvalid);
  assign host_bus.rdata  = ret_data(host_src_q, ctrl_bus.rdata, l2_bus.rdata, ext_rdata_i);

  assign engine_bus.rvalid = eng_rd_q && ret_valid(eng_src_q, ctrl_bus.rvalid, l2_bus.rvalid);
  assign engine_bus.rdata  = ret_data(eng_src_q, ctrl_bus.rdata, l2_bus.rdata, ext_rdata_i);

endmodule : bus_xbar

// File: logic/l2_sram.sv
`timescale 1ns/10ps

module l2_sram (
  input  logic   clk_i,
  input  logic   rst_n_i,
  mem_bus_if.slv bus
);

  mempool_lite_pkg::data_t mem_q [mempool_lite_pkg::L2NumWords];
  logic [mempool_lite_pkg::L2AddrWidth-1:0] word_idx;

  assign word_idx = bus.addr[mempool_lite_pkg::L2ByteOffset +: mempool_lite_pkg::L2AddrWidth];
  assign bus.gnt  = bus.req;  // Always ready

  always_ff @(posedge clk_i) begin
    if (bus.req && bus.we) begin
      mem_q[word_idx] <= mempool_lite_pkg::apply_be(mem_q[word_idx], bus.wdata, bus.be);
    end
    if (bus.req && !bus.we) bus.rdata <= mem_q[word_idx];
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      bus.rvalid <= 1'b0;
    end else begin
      bus.rvalid <= bus.req && !bus.we;
    end
  end

endmodule : l2_sram

// File: logic/ctrl_registers.sv
`timescale 1ns/10ps

module ctrl_registers (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  mem_bus_if.slv                  bus,
  output logic                    wake_o,
  output mempool_lite_pkg::data_t num_words_o,
  output mempool_lite_pkg::addr_t src_offset_o,
  output logic                    eoc_valid_o
);

  mempool_lite_pkg::reg_offset_t offset;
  mempool_lite_pkg::data_t       eoc_q;
  logic                          wr_en;

  assign offset  = bus.addr[mempool_lite_pkg::CtrlOffsetWidth-1:0];
  assign wr_en   = bus.req && bus.we;
  assign bus.gnt = bus.req;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wake_o       <= 1'b0;
      num_words_o  <= '0;
      src_offset_o <= '0;
      eoc_q        <= '0;
      eoc_valid_o  <= 1'b0;
      bus.rvalid   <= 1'b0;
    end else begin
      wake_o     <= wr_en && offset == mempool_lite_pkg::WakeUpOffset;  // Single-cycle pulse
      bus.rvalid <= bus.req && !bus.we;
      if (wr_en) begin
        unique case (offset)
          mempool_lite_pkg::WakeUpOffset: eoc_valid_o <= 1'b0;  // New run pending
          mempool_lite_pkg::NumWordsOffset:
            num_words_o <= mempool_lite_pkg::apply_be(num_words_o, bus.wdata, bus.be);
          mempool_lite_pkg::SrcOffsetOffset:
            src_offset_o <= mempool_lite_pkg::apply_be(src_offset_o, bus.wdata, bus.be);
          mempool_lite_pkg::EocOffset: begin
            eoc_q       <= mempool_lite_pkg::apply_be(eoc_q, bus.wdata, bus.be);
            eoc_valid_o <= 1'b1;
          end
          default: ;
        endcase
      end
    end
  end

  // Read data
  always_ff @(posedge clk_i) begin
    if (bus.req && !bus.we) begin
      unique case (offset)
        mempool_lite_pkg::NumWordsOffset:  bus.rdata <= num_words_o;
        mempool_lite_pkg::SrcOffsetOffset: bus.rdata <= src_offset_o;
        mempool_lite_pkg::EocOffset:       bus.rdata <= eoc_q;
        default:                           bus.rdata <= '0;
      endcase
    end
  end

endmodule : ctrl_registers

// File: logic/run_fsm.sv
`timescale 1ns/10ps

module run_fsm (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic                         fetch_en_i,
  input  logic                         wake_i,
  input  logic                         gnt_i,
  input  logic                         rvalid_i,
  input  logic                         count_zero_i,
  output mempool_lite_pkg::run_state_e state_o,
  output logic                         load_o,
  output logic                         dec_o,
  output logic                         busy_o
);

  mempool_lite_pkg::run_state_e state_q, state_d;

  always_comb begin
    state_d = state_q;
    load_o  = 1'b0;
    dec_o   = 1'b0;
    unique case (state_q)
      mempool_lite_pkg::Idle: begin
        if (wake_i && fetch_en_i) begin
          load_o  = 1'b1;
          // count_zero_i already reflects the value being loaded
          state_d = count_zero_i ? mempool_lite_pkg::WriteEoc : mempool_lite_pkg::Fetch;
        end
      end
      mempool_lite_pkg::Fetch: if (gnt_i) state_d = mempool_lite_pkg::Wait;
      mempool_lite_pkg::Wait: begin
        if (rvalid_i) begin
          dec_o   = 1'b1;
          state_d = count_zero_i ? mempool_lite_pkg::WriteEoc : mempool_lite_pkg::Fetch;
        end
      end
      mempool_lite_pkg::WriteEoc: if (gnt_i) state_d = mempool_lite_pkg::Idle;
      default: state_d = mempool_lite_pkg::Idle;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) state_q <= mempool_lite_pkg::Idle;
    else          state_q <= state_d;
  end

  assign state_o = state_q;
  assign busy_o  = state_q != mempool_lite_pkg::Idle;

endmodule : run_fsm

// File: logic/word_counter.sv
`timescale 1ns/10ps

module word_counter (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    load_i,
  input  mempool_lite_pkg::data_t load_value_i,
  input  logic                    dec_i,
  output logic                    count_zero_o
);

  mempool_lite_pkg::data_t count_q, count_d;

  always_comb begin
    count_d = count_q;
    if (load_i) count_d = load_value_i;
    else if (dec_i && count_q != '0) count_d = count_q - 1'b1;  // Saturates at zero
  end

  // Zero after this cycle's update
  assign count_zero_o = count_d == '0;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) count_q <= '0;
    else          count_q <= count_d;
  end

endmodule : word_counter

// File: logic/sum_engine.sv
`timescale 1ns/10ps

module sum_engine (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  mempool_lite_pkg::run_state_e state_i,
  input  logic                         load_i,
  input  mempool_lite_pkg::addr_t      src_offset_i,
  mem_bus_if.mst                       bus
);

  mempool_lite_pkg::addr_t addr_q;
  mempool_lite_pkg::data_t acc_q;
  logic                    fetching, writing;

  assign fetching = state_i == mempool_lite_pkg::Fetch;
  assign writing  = state_i == mempool_lite_pkg::WriteEoc;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      addr_q <= mempool_lite_pkg::L2BaseAddr;
      acc_q  <= '0;
    end else if (load_i) begin
      addr_q <= mempool_lite_pkg::L2BaseAddr + src_offset_i;
      acc_q  <= '0;
    end else begin
      if (fetching && bus.gnt) addr_q <= addr_q + mempool_lite_pkg::AddrWidth'(4);
      // Wraps modulo 2^32
      if (state_i == mempool_lite_pkg::Wait && bus.rvalid) acc_q <= acc_q + bus.rdata;
    end
  end

  // Request stays up until granted as the state only moves on gnt
  assign bus.req   = fetching || writing;
  assign bus.we    = writing;
  assign bus.addr  = writing ? mempool_lite_pkg::CtrlBaseAddr
                               + mempool_lite_pkg::addr_t'(mempool_lite_pkg::EocOffset)
                             : addr_q;
  assign bus.wdata = acc_q;
  assign bus.be    = '1;

endmodule : sum_engine

// File: logic/mempool_lite_system.sv
`timescale 1ns/10ps

module mempool_lite_system (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    fetch_en_i,
  input  logic                    host_req_i,
  input  logic                    host_we_i,
  input  mempool_lite_pkg::addr_t host_addr_i,
  input  mempool_lite_pkg::data_t host_wdata_i,
  input  mempool_lite_pkg::strb_t host_be_i,
  output logic                    host_gnt_o,
  output logic                    host_rvalid_o,
  output mempool_lite_pkg::data_t host_rdata_o,
  output logic                    ext_req_o,
  output logic                    ext_we_o,
  output mempool_lite_pkg::addr_t ext_addr_o,
  output mempool_lite_pkg::data_t ext_wdata_o,
  output mempool_lite_pkg::strb_t ext_be_o,
  input  mempool_lite_pkg::data_t ext_rdata_i,
  output logic                    busy_o,
  output logic                    eoc_valid_o
);

  mem_bus_if host_bus ();
  mem_bus_if engine_bus ();
  mem_bus_if ctrl_bus ();
  mem_bus_if l2_bus ();

  logic                         wake, load, dec, count_zero;
  mempool_lite_pkg::data_t      num_words;
  mempool_lite_pkg::addr_t      src_offset;
  mempool_lite_pkg::run_state_e run_state;

  // Host port onto the bus
  assign host_bus.req   = host_req_i;
  assign host_bus.we    = host_we_i;
  assign host_bus.addr  = host_addr_i;
  assign host_bus.wdata = host_wdata_i;
  assign host_bus.be    = host_be_i;
  assign host_gnt_o     = host_bus.gnt;
  assign host_rvalid_o  = host_bus.rvalid;
  assign host_rdata_o   = host_bus.rdata;

  bus_xbar i_bus_xbar (
    .clk_i      (clk_i      ),
    .rst_n_i    (rst_n_i    ),
    .host_bus   (host_bus   ),
    .engine_bus (engine_bus ),
    .ctrl_bus   (ctrl_bus   ),
    .l2_bus     (l2_bus     ),
    .ext_req_o  (ext_req_o  ),
    .ext_we_o   (ext_we_o   ),
    .ext_addr_o (ext_addr_o ),
    .ext_wdata_o(ext_wdata_o),
    .ext_be_o   (ext_be_o   ),
    .ext_rdata_i(ext_rdata_i)
  );

  l2_sram i_l2_sram (
    .clk_i  (clk_i  ),
    .rst_n_i(rst_n_i),
    .bus    (l2_bus )
  );

  ctrl_registers i_ctrl_registers (
    .clk_i       (clk_i      ),
    .rst_n_i     (rst_n_i    ),
    .bus         (ctrl_bus   ),
    .wake_o      (wake       ),
    .num_words_o (num_words  ),
    .src_offset_o(src_offset ),
    .eoc_valid_o (eoc_valid_o)
  );

  run_fsm i_run_fsm (
    .clk_i       (clk_i            ),
    .rst_n_i     (rst_n_i          ),
    .fetch_en_i  (fetch_en_i       ),
    .wake_i      (wake             ),
    .gnt_i       (engine_bus.gnt   ),
    .rvalid_i    (engine_bus.rvalid),
    .count_zero_i(count_zero       ),
    .state_o     (run_state        ),
    .load_o      (load             ),
    .dec_o       (dec              ),
    .busy_o      (busy_o           )
  );

  word_counter i_word_counter (
    .clk_i       (clk_i     ),
    .rst_n_i     (rst_n_i   ),
    .load_i      (load      ),
    .load_value_i(num_words ),
    .dec_i       (dec       ),
    .count_zero_o(count_zero)
  );

  sum_engine i_sum_engine (
    .clk_i       (clk_i     ),
    .rst_n_i     (rst_n_i   ),
    .state_i     (run_state ),
    .load_i      (load      ),
    .src_offset_i(src_offset),
    .bus         (engine_bus)
  );

endmodule : mempool_lite_system

// File: verification/tb_mempool_lite_system.sv
`timescale 1ns/10ps

module tb_mempool_lite_system;

  localparam int unsigned FillWords   = 64;
  localparam int unsigned L2Ops       = 40;
  localparam int unsigned ExtOps      = 8;
  localparam int unsigned NumRuns     = 12;
  localparam int unsigned ReadsPerRun = 4;
  localparam int unsigned MaxWords    = 16;
  // Host accesses plus engine reads and EOC writes
  localparam int unsigned TotalOps   = FillWords + 2 * L2Ops + 2 * ExtOps + 8
                                     + NumRuns * (4 + ReadsPerRun + MaxWords + 1);
  localparam int unsigned CycleLimit = 40 * TotalOps + 2000;

  logic        clk, rst_n, fetch_en;
  logic        host_req, host_we, host_gnt, host_rvalid;
  logic [31:0] host_addr, host_wdata, host_rdata;
  logic [3:0]  host_be;
  logic        ext_req, ext_we;
  logic [31:0] ext_addr, ext_wdata, ext_rdata;
  logic [3:0]  ext_be;
  logic        busy, eoc_valid;

  logic [31:0] l2_model [FillWords];
  logic [31:0] num_words_model, src_offset_model;
  int unsigned errors, cycles, runs_done;
  logic        busy_prev;

  mempool_lite_system mempool_lite_system_inst (
    .clk_i        (clk        ),
    .rst_n_i      (rst_n      ),
    .fetch_en_i   (fetch_en   ),
    .host_req_i   (host_req   ),
    .host_we_i    (host_we    ),
    .host_addr_i  (host_addr  ),
    .host_wdata_i (host_wdata ),
    .host_be_i    (host_be    ),
    .ext_rdata_i  (ext_rdata  ),
    .host_gnt_o   (host_gnt   ),
    .host_rvalid_o(host_rvalid),
    .host_rdata_o (host_rdata ),
    .ext_req_o    (ext_req    ),
    .ext_we_o     (ext_we     ),
    .ext_addr_o   (ext_addr   ),
    .ext_wdata_o  (ext_wdata  ),
    .ext_be_o     (ext_be     ),
    .busy_o       (busy       ),
    .eoc_valid_o  (eoc_valid  )
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= CycleLimit) begin
      $display("Timeout: simulation stopped after %0d cycles", cycles);
      $display("Errors: %0d", errors);
      $display("Test failures found");
      $finish;
    end
  end

  // Busy falls in the same cycle the EOC flag rises
  always @(negedge clk) begin
    if (busy_prev && !busy) begin
      runs_done++;
      check_value("eoc_valid_o", eoc_valid, 32'd1);
    end else if (busy === 1'b1) begin
      check_value("eoc_valid_o", eoc_valid, 32'd0);
    end
    busy_prev = busy;
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp);
    end
  endtask

  function automatic logic [31:0] merge_bytes(logic [31:0] old_w, logic [31:0] new_w,
                                              logic [3:0] be);
    logic [31:0] res;
    res = old_w;
    for (int i = 0; i < 4; i++) begin
      if (be[i]) res[8*i +: 8] = new_w[8*i +: 8];
    end
    return res;
  endfunction

  task automatic bus_access(input logic we, input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] be, input logic to_ext,
                            output logic [31:0] rdata);
    int unsigned waits;
    logic [31:0] ext_word;
    waits = 0;
    @(posedge clk);
    #1;
    host_req   = 1'b1;
    host_we    = we;
    host_addr  = addr;
    host_wdata = wdata;
    host_be    = be;
    @(negedge clk);
    while (!host_gnt) begin
      waits++;
      @(negedge clk);
    end
    if (waits != 0) begin
      errors++;
      $display("Host access to 0x%08h waited %0d cycles for its grant", addr, waits);
    end
    if (to_ext) begin
      check_value("ext_req_o", ext_req, 32'd1);
      check_value("ext_we_o", ext_we, we);
      check_value("ext_addr_o", ext_addr, addr);
      check_value("ext_wdata_o", ext_wdata, wdata);
      check_value("ext_be_o", ext_be, be);
    end
    @(posedge clk);
    #1;
    host_req = 1'b0;
    rdata    = 'x;
    if (!we) begin
      ext_word  = $urandom;  // External slave answers in the return cycle
      ext_rdata = ext_word;
      @(negedge clk);
      check_value("host_rvalid_o", host_rvalid, 32'd1);
      rdata = host_rdata;
      if (to_ext) check_value("host_rdata_o", host_rdata, ext_word);
    end
  endtask

  // Upper bits inside the window alias onto the same word
  function automatic logic [31:0] l2_addr(int unsigned idx);
    return 32'h8000_0000 | ($urandom & 32'h3FFF_F000) | (idx << 2);
  endfunction

  task automatic l2_write(input int unsigned idx, input logic [31:0] data,
                          input logic [3:0] be);
    logic [31:0] unused;
    bus_access(1'b1, l2_addr(idx), data, be, 1'b0, unused);
    l2_model[idx] = merge_bytes(l2_model[idx], data, be);
  endtask

  task automatic l2_read_check(input int unsigned idx);
    logic [31:0] data;
    bus_access(1'b0, l2_addr(idx), '0, 4'hF, 1'b0, data);
    check_value("host_rdata_o", data, l2_model[idx]);
  endtask

  task automatic reg_write(input logic [15:0] offset, input logic [31:0] data);
    logic [31:0] unused;
    bus_access(1'b1, 32'h4000_0000 | offset, data, 4'hF, 1'b0, unused);
  endtask

  task automatic reg_read(input logic [15:0] offset, output logic [31:0] data);
    bus_access(1'b0, 32'h4000_0000 | offset, '0, 4'hF, 1'b0, data);
  endtask

  task automatic start_run(input int unsigned start_idx, input int unsigned count,
                           input bit contend);
    logic [31:0] expected, eoc_word;
    int unsigned done_before, waited;
    expected = '0;
    for (int i = 0; i < count; i++) expected += l2_model[start_idx + i];
    reg_write(16'h0004, count);
    reg_write(16'h0008, start_idx * 4);
    done_before = runs_done;
    reg_write(16'h0000, 32'h1);
    waited = 0;
    while (!busy && waited < 6) begin
      @(negedge clk);
      waited++;
    end
    if (!busy) begin
      errors++;
      $display("busy_o did not rise after a wake write with %0d words", count);
    end else begin
      if (contend) begin
        repeat (ReadsPerRun) l2_read_check($urandom % FillWords);
      end
      while (runs_done == done_before) @(posedge clk);
      reg_read(16'h000C, eoc_word);
      check_value("eoc", eoc_word, expected);
    end
  endtask

  initial begin
    logic [31:0] data;
    logic [31:0] ext_a;
    int unsigned idx, count;
    void'($urandom(74));
    errors     = 0;
    cycles     = 0;
    runs_done  = 0;
    busy_prev  = 1'b0;
    rst_n      = 1'b0;
    fetch_en   = 1'b0;
    host_req   = 1'b0;
    host_we    = 1'b0;
    host_addr  = '0;
    host_wdata = '0;
    host_be    = '0;
    ext_rdata  = '0;
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    check_value("busy_o", busy, 32'd0);
    check_value("eoc_valid_o", eoc_valid, 32'd0);
    check_value("ext_req_o", ext_req, 32'd0);
    check_value("host_rvalid_o", host_rvalid, 32'd0);

    for (int i = 0; i < FillWords; i++) l2_write(i, $urandom, 4'hF);
    repeat (L2Ops) begin
      l2_write($urandom % FillWords, $urandom, 4'($urandom));
      l2_read_check($urandom % FillWords);
    end

    repeat (ExtOps) begin
      ext_a = $urandom & 32'hFFFF_FFFC;
      if ((ext_a >= 32'h4000_0000 && ext_a <= 32'h4000_FFFF) ||
          (ext_a >= 32'h8000_0000 && ext_a <= 32'hBFFF_FFFF)) ext_a ^= 32'h4000_0000;
      bus_access(1'b1, ext_a, $urandom, 4'($urandom), 1'b1, data);
      bus_access(1'b0, ext_a, '0, 4'hF, 1'b1, data);
    end

    num_words_model  = $urandom;
    src_offset_model = $urandom;
    reg_write(16'h0004, num_words_model);
    reg_write(16'h0008, src_offset_model);
    reg_read(16'h0004, data);
    check_value("num_words", data, num_words_model);
    reg_read(16'h0008, data);
    check_value("src_offset", data, src_offset_model);

    // Wake while fetch is disabled
    reg_write(16'h0000, 32'h1);
    repeat (8) begin
      @(negedge clk);
      check_value("busy_o", busy, 32'd0);
      check_value("eoc_valid_o", eoc_valid, 32'd0);
    end

    @(posedge clk);
    #1;
    fetch_en = 1'b1;
    for (int r = 0; r < NumRuns; r++) begin
      count = (r == 0) ? 0 : $urandom % (MaxWords + 1);
      idx   = $urandom % (FillWords - count + 1);
      start_run(idx, count, r >= NumRuns / 2);  // Second half races host reads
    end

    repeat (4) @(posedge clk);
    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule : tb_mempool_lite_system

// File: mempool_lite.f
logic/mempool_lite_pkg.sv
logic/mem_bus_if.sv
logic/bus_xbar.sv
logic/l2_sram.sv
logic/ctrl_registers.sv
logic/run_fsm.sv
logic/word_counter.sv
logic/sum_engine.sv
logic/mempool_lite_system.sv
verification/tb_mempool_lite_system.sv

// File: Bender.yml
package:
  name: mempool_lite

sources:
  - logic/mempool_lite_pkg.sv
  - logic/mem_bus_if.sv
  - logic/bus_xbar.sv
  - logic/l2_sram.sv
  - logic/ctrl_registers.sv
  - logic/run_fsm.sv
  - logic/word_counter.sv
  - logic/sum_engine.sv
  - logic/mempool_lite_system.sv
  - target: test
    files:
      - verification/tb_mempool_lite_system.sv
